// File: all.f
design/csr_pkg.sv
design/csr_decode.sv
design/csr_exec_lane.sv
design/csr_wb_merge.sv
design/csr_subsys.sv
bench/tb_clock.sv
bench/tb_csr_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# Build the CSR subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_csr_subsys -o sim_csr -f all.f

# The simulator exits nonzero on failure, so keep the output and decide by the pass line
output=$(./obj_dir/sim_csr 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: bench/tb_csr_subsys.sv
`timescale 1ns/1ps
// Testbench for the CSR execution subsystem
// Drives directed and random Zicsr traffic, keeps a shadow CSR bank per hart
// and checks the writeback port in every slot, three cycles after issue
module tb_csr_subsys
    import csr_pkg::*;
();

    localparam logic [6:0] SYSTEM_OPCODE  = 7'b1110011;
    localparam logic [2:0] F3_RW          = 3'b001;
    localparam logic [2:0] F3_RS          = 3'b010;
    localparam logic [2:0] F3_RC          = 3'b011;
    localparam logic [2:0] F3_RWI         = 3'b101;
    localparam logic [2:0] F3_RSI         = 3'b110;
    localparam logic [2:0] F3_RCI         = 3'b111;
    localparam int         RANDOM_COUNT   = 400;
    localparam int         DIRECTED_SLOTS = 120;   // Upper bound on reset, directed and drain slots
    localparam int         TIMEOUT_NS     = (DIRECTED_SLOTS + RANDOM_COUNT) * 8 + 400;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] rs1_data;
    logic [1:0]  hart_id;
    logic        wb_valid;
    logic [1:0]  wb_hart;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic        chk_on;                          // Goes high after the first edge in reset
    logic        chk_valid;
    logic [1:0]  chk_hart;
    logic [4:0]  chk_rd;
    logic [31:0] chk_data;
    string       chk_name;
    string       cur_test;
    logic        q_valid [$];                     // One entry per slot, checked three slots later
    logic [1:0]  q_hart [$];
    logic [4:0]  q_rd [$];
    logic [31:0] q_data [$];
    string       q_name [$];
    logic [31:0] shadow [4][4];                   // Hart by mscratch, mepc, mcause, mtvec
    logic [31:0] rng_state;

    tb_clock #(.PERIOD_NS(8)) tb_clock_i (.clk(clk));

    csr_subsys csr_subsys_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .hart_id    (hart_id),
        .wb_valid   (wb_valid),
        .wb_hart    (wb_hart),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // ************************************************************
    // Stimulus helpers and reference model
    // ************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // The old CSR value always goes to rd
    task automatic run_model(input logic v, input logic [31:0] ins, input logic [31:0] rs1,
                             input logic [1:0] hart, output logic e_valid,
                             output logic [4:0] e_rd, output logic [31:0] e_data);
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [11:0] addr;
        logic [31:0] opnd;
        logic [31:0] old;
        logic [31:0] upd;
        logic [1:0]  slot;
        logic        hit;
        f3      = ins[14:12];
        src     = ins[19:15];
        addr    = ins[31:20];
        e_rd    = ins[11:7];
        e_valid = 1'b0;
        e_data  = '0;
        if (v && ins[6:0] == SYSTEM_OPCODE && f3[1:0] != 2'b00) begin
            opnd = f3[2] ? {27'd0, src} : rs1;    // Immediate forms zero-extend the field
            hit  = 1'b1;
            slot = 2'd0;
            case (addr)
                CSR_MSCRATCH: slot = 2'd0;
                CSR_MEPC:     slot = 2'd1;
                CSR_MCAUSE:   slot = 2'd2;
                CSR_MTVEC:    slot = 2'd3;
                default:      hit = 1'b0;
            endcase
            if (hit) begin
                old = shadow[hart][slot];
            end else if (addr == CSR_MHARTID) begin
                old = {30'd0, hart};
            end else begin
                old = '0;                          // Unknown CSR reads zero
            end
            case (f3[1:0])
                2'b01:   upd = opnd;
                2'b10:   upd = old | opnd;
                default: upd = old & ~opnd;
            endcase
            if (hit && (f3[1:0] == 2'b01 || src != 5'd0)) begin
                shadow[hart][slot] = upd;
            end
            e_valid = (e_rd != 5'd0);              // x0 is never written back
            e_data  = old;
        end
    endtask

    task automatic drive_slot(input logic v, input logic [31:0] ins, input logic [31:0] rs1,
                              input logic [1:0] hart);
        logic        e_valid;
        logic [4:0]  e_rd;
        logic [31:0] e_data;
        @(negedge clk);
        inst_valid = v;
        inst       = ins;
        rs1_data   = rs1;
        hart_id    = hart;
        run_model(v, ins, rs1, hart, e_valid, e_rd, e_data);
        q_valid.push_back(e_valid);
        q_hart.push_back(hart);
        q_rd.push_back(e_rd);
        q_data.push_back(e_data);
        q_name.push_back(cur_test);
        chk_valid = 1'b0;
        if (q_valid.size() > 3) begin              // Entry from three slots back is due now
            chk_valid = q_valid.pop_front();
            chk_hart  = q_hart.pop_front();
            chk_rd    = q_rd.pop_front();
            chk_data  = q_data.pop_front();
            chk_name  = q_name.pop_front();
        end
        chk_on = 1'b1;
    endtask

    task automatic idle_slot();
        drive_slot(1'b0, 32'h0000_0013, 32'd0, 2'd0);
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] src,
                          input logic [4:0] rd, input logic [31:0] rs1, input logic [1:0] hart);
        drive_slot(1'b1, {addr, src, f3, rd, SYSTEM_OPCODE}, rs1, hart);
    endtask

    // ************************************************************
    // Writeback checks, watchdog
    // ************************************************************

    task automatic report_mismatch(input string field, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s: %s expected 0x%08h actual 0x%08h", chk_name, field, exp, act);
        $display("Checks failed");
        $fatal(1, "writeback port mismatch");
    endtask

    // Outputs are read before this edge's updates land, so they hold the last cycle's value
    always @(posedge clk) begin
        if (chk_on) begin
            valid_ok: assert (wb_valid == chk_valid)
                else report_mismatch("wb_valid", {31'd0, chk_valid}, {31'd0, wb_valid});
            if (chk_valid) begin
                hart_ok: assert (wb_hart == chk_hart)
                    else report_mismatch("wb_hart", {30'd0, chk_hart}, {30'd0, wb_hart});
                rd_ok: assert (wb_rd == chk_rd)
                    else report_mismatch("wb_rd", {27'd0, chk_rd}, {27'd0, wb_rd});
                data_ok: assert (wb_data == chk_data)
                    else report_mismatch("wb_data", chk_data, wb_data);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not finish in %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        logic [31:0] r;
        logic [11:0] addr;
        logic [4:0]  src;
        rst_n      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_data   = '0;
        hart_id    = '0;
        chk_on     = 1'b0;
        chk_valid  = 1'b0;
        chk_hart   = '0;
        chk_rd     = '0;
        chk_data   = '0;
        chk_name   = "reset";
        cur_test   = "reset";
        rng_state  = 32'd63;
        for (int h = 0; h < 4; h++) begin
            for (int s = 0; s < 4; s++) begin
                shadow[h][s] = '0;
            end
        end
        repeat (4) idle_slot();                    // Four rising edges with reset high
        rst_n = 1'b0;

        cur_test = "first_wb";                     // Quiet until the first CSR instruction
        repeat (3) idle_slot();
        drive_slot(1'b1, 32'h0050_0093, 32'h55, 2'd0);
        csr_op(F3_RS, CSR_MSCRATCH, 5'd0, 5'd5, 32'hFFFF_FFFF, 2'd0);
        repeat (4) idle_slot();

        cur_test = "rw_readback";                  // Back to back on hart 1
        csr_op(F3_RW, CSR_MEPC, 5'd7, 5'd6, 32'hDEAD_BEEF, 2'd1);
        csr_op(F3_RS, CSR_MEPC, 5'd0, 5'd8, 32'h0, 2'd1);
        csr_op(F3_RWI, CSR_MTVEC, 5'd21, 5'd9, 32'h0, 2'd1);
        csr_op(F3_RW, CSR_MTVEC, 5'd3, 5'd10, 32'h0000_1234, 2'd1);
        csr_op(F3_RS, CSR_MTVEC, 5'd0, 5'd11, 32'h0, 2'd1);

        cur_test = "set_clear";                    // Zero source fields must leave the CSR alone
        csr_op(F3_RW, CSR_MSCRATCH, 5'd1, 5'd12, 32'hF0F0_00FF, 2'd2);
        csr_op(F3_RS, CSR_MSCRATCH, 5'd3, 5'd13, 32'h0F00_0000, 2'd2);
        csr_op(F3_RC, CSR_MSCRATCH, 5'd4, 5'd14, 32'h0000_000F, 2'd2);
        csr_op(F3_RSI, CSR_MSCRATCH, 5'd6, 5'd15, 32'h0, 2'd2);
        csr_op(F3_RCI, CSR_MSCRATCH, 5'd16, 5'd16, 32'h0, 2'd2);
        csr_op(F3_RS, CSR_MSCRATCH, 5'd0, 5'd17, 32'hFFFF_FFFF, 2'd2);
        csr_op(F3_RC, CSR_MSCRATCH, 5'd0, 5'd18, 32'hFFFF_FFFF, 2'd2);
        csr_op(F3_RCI, CSR_MSCRATCH, 5'd0, 5'd19, 32'h0, 2'd2);
        csr_op(F3_RSI, CSR_MSCRATCH, 5'd0, 5'd20, 32'h0, 2'd2);

        cur_test = "hart_isolation";
        for (int h = 0; h < 4; h++) begin
            csr_op(F3_RW, CSR_MCAUSE, 5'd1, 5'd2, 32'h1000_0000 + 32'(h) * 32'h11, 2'(h));
        end
        for (int h = 0; h < 4; h++) begin
            csr_op(F3_RS, CSR_MCAUSE, 5'd0, 5'd3, 32'h0, 2'(h));
            csr_op(F3_RW, CSR_MHARTID, 5'd1, 5'd4, 32'hFFFF_FFFF, 2'(h));
            csr_op(F3_RS, CSR_MHARTID, 5'd0, 5'd5, 32'h0, 2'(h));
        end
        csr_op(F3_RW, 12'h7C0, 5'd2, 5'd6, 32'hCAFE_F00D, 2'd3);     // Unimplemented address
        csr_op(F3_RS, 12'h7C0, 5'd0, 5'd7, 32'h0, 2'd3);

        cur_test = "rd_zero";
        csr_op(F3_RW, CSR_MSCRATCH, 5'd9, 5'd0, 32'h0000_A5A5, 2'd3);
        csr_op(F3_RS, CSR_MSCRATCH, 5'd0, 5'd21, 32'h0, 2'd3);
        drive_slot(1'b1, 32'h0000_0073, 32'h1, 2'd3);                // ECALL
        drive_slot(1'b1, {CSR_MSCRATCH, 5'd1, 3'b100, 5'd22, SYSTEM_OPCODE}, 32'h1, 2'd3);
        drive_slot(1'b1, 32'h1234_5237, 32'h1, 2'd0);                // LUI
        drive_slot(1'b0, {CSR_MSCRATCH, 5'd1, F3_RW, 5'd23, SYSTEM_OPCODE}, 32'h1, 2'd3);
        csr_op(F3_RS, CSR_MSCRATCH, 5'd0, 5'd24, 32'h0, 2'd3);

        cur_test = "random_stream";
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r = next_rand();
            case (r[4:2])
                3'd0:    addr = CSR_MSCRATCH;
                3'd1:    addr = CSR_MEPC;
                3'd2:    addr = CSR_MCAUSE;
                3'd3:    addr = CSR_MTVEC;
                3'd4:    addr = CSR_MHARTID;
                3'd5:    addr = 12'h7C0;
                3'd6:    addr = CSR_MSCRATCH;
                default: addr = CSR_MEPC;
            endcase
            src = (r[10:8] == 3'd0) ? 5'd0 : r[15:11];              // Zero source about one in eight
            drive_slot(r[23:21] != 3'd0, {addr, src, r[7:5], r[20:16], SYSTEM_OPCODE},
                       next_rand(), r[1:0]);
        end

        repeat (5) idle_slot();                    // Let the last results reach the check
        @(posedge clk);
        #1;
        $display("All checks passed");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps
// Testbench clock source
// Free-running clock, low at time zero, first rising edge half a period in
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                                // Known level before the first edge
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: design/csr_subsys.sv
`timescale 1ns/1ps
// CSR execution subsystem for a multi-hart barrel core
// Decode stage, one CSR lane per hart and a writeback merge, giving a fixed
// three-cycle path from instruction strobe to register-file write
module csr_subsys
    import csr_pkg::*;
#(
    parameter int  XLEN      = 32,
    parameter int  NUM_HARTS = 4,
    localparam int HID_W     = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [XLEN-1:0]  rs1_data,
    input  logic [HID_W-1:0] hart_id,
    output logic             wb_valid,
    output logic [HID_W-1:0] wb_hart,
    output logic [4:0]       wb_rd,
    output logic [XLEN-1:0]  wb_data
);

    logic [NUM_HARTS-1:0] issue;
    csr_op_e              op;
    logic [XLEN-1:0]      operand;
    logic                 csr_we;
    logic [11:0]          csr_addr;
    logic [4:0]           rd;
    logic [NUM_HARTS-1:0] lane_out_en;
    logic [4:0]           lane_rd      [NUM_HARTS];
    logic [XLEN-1:0]      lane_rd_data [NUM_HARTS];

    csr_decode #(
        .XLEN      (XLEN),
        .NUM_HARTS (NUM_HARTS)
    ) csr_decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .hart_id    (hart_id),
        .issue      (issue),
        .op         (op),
        .operand    (operand),
        .csr_we     (csr_we),
        .csr_addr   (csr_addr),
        .rd         (rd)
    );

    // Every lane sees the shared decode bus; only its issue bit differs
    for (genvar g = 0; g < NUM_HARTS; g++) begin : g_lane
        csr_exec_lane #(
            .XLEN    (XLEN),
            .HART_ID (g)
        ) csr_exec_lane_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .issue    (issue[g]),
            .op       (op),
            .operand  (operand),
            .csr_we   (csr_we),
            .csr_addr (csr_addr),
            .rd       (rd),
            .out_en   (lane_out_en[g]),
            .rd_out   (lane_rd[g]),
            .rd_data  (lane_rd_data[g])
        );
    end

    csr_wb_merge #(
        .XLEN      (XLEN),
        .NUM_HARTS (NUM_HARTS)
    ) csr_wb_merge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_out_en  (lane_out_en),
        .lane_rd      (lane_rd),
        .lane_rd_data (lane_rd_data),
        .wb_valid     (wb_valid),
        .wb_hart      (wb_hart),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

// File: design/csr_wb_merge.sv
`timescale 1ns/1ps
// Writeback merge for the CSR lanes
// Picks the one lane with a result this cycle, encodes its hart index and
// drives a single registered register-file write port
module csr_wb_merge #(
    parameter int  XLEN      = 32,
    parameter int  NUM_HARTS = 4,
    localparam int HID_W     = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_HARTS-1:0] lane_out_en,                   // At most one bit set
    input  logic [4:0]           lane_rd      [NUM_HARTS],
    input  logic [XLEN-1:0]      lane_rd_data [NUM_HARTS],
    output logic                 wb_valid,
    output logic [HID_W-1:0]     wb_hart,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data
);

    logic             sel_valid;
    logic [HID_W-1:0] sel_hart;
    logic [4:0]       sel_rd;
    logic [XLEN-1:0]  sel_data;

    // Issue is one-hot upstream, so the last match is the only match
    always_comb begin
        sel_valid = 1'b0;
        sel_hart  = '0;
        sel_rd    = '0;
        sel_data  = '0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (lane_out_en[h]) begin
                sel_valid = 1'b1;
                sel_hart  = HID_W'(h);
                sel_rd    = lane_rd[h];
                sel_data  = lane_rd_data[h];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= sel_valid && (sel_rd != 5'd0);   // x0 is hardwired, nothing to write
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            wb_hart <= sel_hart;
            wb_rd   <= sel_rd;
            wb_data <= sel_data;
        end
    end

endmodule

// File: design/csr_exec_lane.sv
`timescale 1ns/1ps
// CSR execution lane for a single hart
// Holds the hart's machine CSR bank and performs the read-modify-write of
// one Zicsr operation per issue, returning the old value for rd
module csr_exec_lane
    import csr_pkg::*;
#(
    parameter int XLEN    = 32,
    parameter int HART_ID = 0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,          // This lane owns the decoded instruction
    input  csr_op_e         op,
    input  logic [XLEN-1:0] operand,
    input  logic            csr_we,
    input  logic [11:0]     csr_addr,
    input  logic [4:0]      rd,
    output logic            out_en,         // Result strobe toward the merge stage
    output logic [4:0]      rd_out,
    output logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] old_val;          // Value before the operation, goes to rd
    logic [XLEN-1:0] new_val;
    logic            writable;
    logic            do_write;

    // ************************************************************
    // CSR read and modify
    // ************************************************************

    always_comb begin
        writable = 1'b1;
        case (csr_addr)
            CSR_MSCRATCH: old_val = mscratch;
            CSR_MEPC:     old_val = mepc;
            CSR_MCAUSE:   old_val = mcause;
            CSR_MTVEC:    old_val = mtvec;
            CSR_MHARTID: begin
                old_val  = XLEN'(HART_ID);     // Fixed per lane by the generate index
                writable = 1'b0;
            end
            default: begin
                old_val  = '0;                 // Unimplemented CSRs read as zero
                writable = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (op)
            CSR_RS:  new_val = old_val | operand;
            CSR_RC:  new_val = old_val & ~operand;
            CSR_RW:  new_val = operand;
            default: new_val = old_val;
        endcase
    end

    assign do_write = issue && csr_we && writable;

    // ************************************************************
    // CSR bank
    // ************************************************************

    // Update lands on the same edge as the result, so the next
    // instruction to this hart already reads the new value
    always_ff @(posedge clk) begin
        if (rst_n) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtvec    <= '0;
        end else if (do_write) begin
            case (csr_addr)
                CSR_MSCRATCH: mscratch <= new_val;
                CSR_MEPC:     mepc     <= new_val;
                CSR_MCAUSE:   mcause   <= new_val;
                CSR_MTVEC:    mtvec    <= new_val;
                default:      ;                 // Filtered out by writable
            endcase
        end
    end

    // ************************************************************
    // Result register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst_n) begin
            out_en <= 1'b0;
        end else begin
            out_en <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_out  <= rd;
            rd_data <= old_val;                // Zicsr returns the value before the update
        end
    end

endmodule

// File: design/csr_decode.sv
`timescale 1ns/1ps
// CSR instruction decoder
// Picks the six Zicsr instructions out of the incoming stream, forms the
// operand and CSR write enable, and issues the registered result to the
// lane of the hart that sent it
module csr_decode
    import csr_pkg::*;
#(
    parameter int  XLEN      = 32,
    parameter int  NUM_HARTS = 4,
    localparam int HID_W     = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,    // One instruction per strobe
    input  logic [31:0]          inst,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [HID_W-1:0]     hart_id,
    output logic [NUM_HARTS-1:0] issue,         // One-hot lane select
    output csr_op_e              op,
    output logic [XLEN-1:0]      operand,
    output logic                 csr_we,
    output logic [11:0]          csr_addr,
    output logic [4:0]           rd
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [4:0]           rs1_field;     // Register index or 5-bit immediate
    logic                 use_imm;
    logic                 is_csr;
    csr_op_e              op_nxt;
    logic [XLEN-1:0]      operand_nxt;
    logic                 we_nxt;
    logic [NUM_HARTS-1:0] issue_nxt;

    // ************************************************************
    // Field extraction and classification
    // ************************************************************

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign rs1_field = inst[19:15];
    assign use_imm   = funct3[2];                  // Upper funct3 bit picks the uimm forms

    // funct3 of 000 is ECALL/EBREAK/xRET and 100 is reserved
    assign is_csr = (opcode == OPC_SYSTEM) && (funct3[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b10:   op_nxt = CSR_RS;
            2'b11:   op_nxt = CSR_RC;
            default: op_nxt = CSR_RW;              // 00 never issues, so the value is moot
        endcase
    end

    assign operand_nxt = use_imm ? XLEN'(rs1_field) : rs1_data;    // uimm is zero-extended

    // Set and clear with x0 or a zero immediate only read the CSR
    assign we_nxt = (op_nxt == CSR_RW) || (rs1_field != 5'd0);

    always_comb begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            issue_nxt[h] = inst_valid && is_csr && (hart_id == HID_W'(h));
        end
    end

    // ************************************************************
    // Decode register stage
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst_n) begin
            issue <= '0;
        end else begin
            issue <= issue_nxt;
        end
    end

    always_ff @(posedge clk) begin
        op       <= op_nxt;
        operand  <= operand_nxt;
        csr_we   <= we_nxt;
        csr_addr <= inst[31:20];                   // CSR address sits in the I-type immediate
        rd       <= inst[11:7];
    end

endmodule

// File: design/csr_pkg.sv
// CSR execution block shared definitions
// Operation encoding for the Zicsr instructions, the SYSTEM major opcode
// and the address map of the machine CSRs each hart lane implements
package csr_pkg;

    // ************************************************************
    // Instruction encoding
    // ************************************************************

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;   // Major opcode shared by all Zicsr forms

    // Operation codes follow the low two bits of funct3 so the decoder
    // mapping stays easy to check against the ISA tables
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,     // Write the operand into the CSR
        CSR_RS = 2'b10,     // Set the bits that are one in the operand
        CSR_RC = 2'b11      // Clear the bits that are one in the operand
    } csr_op_e;

    // ************************************************************
    // Machine CSR addresses
    // ************************************************************

    localparam logic [11:0] CSR_MSCRATCH = 12'h340;   // Scratch register for trap handlers
    localparam logic [11:0] CSR_MEPC     = 12'h341;   // Exception return address
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;   // Trap cause code
    localparam logic [11:0] CSR_MTVEC    = 12'h305;   // Trap vector base
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;   // Hart index, read-only

endpackage
